// File: include/tlb_defines.svh
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// TLB geometry, 8, 16 or 32 entries
`define TLB_NUM   16
`define TLB_IDX_W $clog2(`TLB_NUM)

// Field widths
`define VPN2_W    19
`define ASID_W    8
`define PFN_W     20
`define VADDR_W   32
`define PADDR_W   32

`endif

// File: verilog/tlb_pkg.sv
`include "tlb_defines.svh"

package tlb_pkg;

    typedef logic [`VPN2_W-1:0]    vpn2_t;
    typedef logic [`ASID_W-1:0]    asid_t;
    typedef logic [`PFN_W-1:0]     pfn_t;
    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [`VADDR_W-1:0]   vaddr_t;
    typedef logic [`PADDR_W-1:0]   paddr_t;
    typedef logic [2:0]            cattr_t;

    // One page of the even/odd pair, same bit order as EntryLo[25:1]
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;
        logic   v;
    } tlb_lo_t;

    typedef struct packed {
        vpn2_t   vpn2;
        asid_t   asid;
        logic    g;
        tlb_lo_t lo0;
        tlb_lo_t lo1;
    } tlb_entry_t;

    typedef struct packed {
        logic     found;
        tlb_idx_t index;
        tlb_lo_t  lo0;
        tlb_lo_t  lo1;
    } tlb_lookup_t;

    typedef enum logic [1:0] {
        EXC_NONE    = 2'd0,
        EXC_REFILL  = 2'd1,
        EXC_INVALID = 2'd2,
        EXC_MOD     = 2'd3
    } xlate_exc_e;

    typedef struct packed {
        logic       valid;
        paddr_t     paddr;
        cattr_t     cattr;
        xlate_exc_e exc;
    } xlate_rsp_t;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_TLBP  = 3'd1,
        CMD_TLBR  = 3'd2,
        CMD_TLBWI = 3'd3,
        CMD_TLBWR = 3'd4
    } tlb_cmd_e;

    typedef enum logic {
        IDLE,
        CMD_WAIT
    } apb_state_e;

endpackage

// File: verilog/tlb_core.sv
`timescale 1ns/1ns
`include "tlb_defines.svh"

module tlb_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  tlb_pkg::tlb_idx_t    wr_idx,
    input  tlb_pkg::tlb_entry_t  wr_entry,
    input  tlb_pkg::tlb_idx_t    rd_idx,
    output tlb_pkg::tlb_entry_t  rd_entry,
    input  tlb_pkg::asid_t       cur_asid,
    input  tlb_pkg::vpn2_t       i_vpn2,
    input  tlb_pkg::vpn2_t       d_vpn2,
    input  tlb_pkg::vpn2_t       probe_vpn2,
    input  logic                 probe_req,
    output tlb_pkg::tlb_lookup_t i_look,
    output tlb_pkg::tlb_lookup_t d_look
);
    import tlb_pkg::*;

    tlb_entry_t           entries [`TLB_NUM];

    vpn2_t                i_key;
    vpn2_t                d_key;
    asid_t                asid_q;

    logic [`TLB_NUM-1:0]  i_match;
    logic [`TLB_NUM-1:0]  d_match;
    tlb_idx_t             i_idx;
    tlb_idx_t             d_idx;

    function automatic logic entry_hit(input tlb_entry_t ent, input vpn2_t key,
                                       input asid_t asid);
        return (ent.vpn2 == key) && ((ent.asid == asid) || ent.g);
    endfunction

    // Match vector is one-hot when software keeps entries unique
    function automatic tlb_idx_t onehot_to_idx(input logic [`TLB_NUM-1:0] hot);
        tlb_idx_t idx;
        idx = '0;
        for (int n = 0; n < `TLB_NUM; n++) begin
            if (hot[n]) begin
                idx = idx | tlb_idx_t'(n);
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < `TLB_NUM; n++) begin
                entries[n] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    // Lookup keys, results follow one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            i_key  <= '0;
            d_key  <= '0;
            asid_q <= '0;
        end else begin
            i_key  <= i_vpn2;
            d_key  <= probe_req ? probe_vpn2 : d_vpn2; // TLBP borrows data port
            asid_q <= cur_asid;
        end
    end

    always_comb begin
        for (int n = 0; n < `TLB_NUM; n++) begin
            i_match[n] = entry_hit(entries[n], i_key, asid_q);
            d_match[n] = entry_hit(entries[n], d_key, asid_q);
        end
    end

    assign i_idx = onehot_to_idx(i_match);
    assign d_idx = onehot_to_idx(d_match);

    assign i_look.found = |i_match;
    assign i_look.index = i_idx;
    assign i_look.lo0   = entries[i_idx].lo0;
    assign i_look.lo1   = entries[i_idx].lo1;

    assign d_look.found = |d_match;
    assign d_look.index = d_idx;
    assign d_look.lo0   = entries[d_idx].lo0;
    assign d_look.lo1   = entries[d_idx].lo1;

    assign rd_entry = entries[rd_idx]; // TLBR path

endmodule

// File: verilog/cp0_tlb_regs.sv
`timescale 1ns/1ns
`include "tlb_defines.svh"

module cp0_tlb_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 wr_en,
    output tlb_pkg::tlb_idx_t    wr_idx,
    output tlb_pkg::tlb_entry_t  wr_entry,
    output tlb_pkg::tlb_idx_t    rd_idx,
    input  tlb_pkg::tlb_entry_t  rd_entry,
    output logic                 probe_req,
    output tlb_pkg::vpn2_t       probe_vpn2,
    output tlb_pkg::asid_t       cur_asid,
    input  tlb_pkg::tlb_lookup_t probe_look
);
    import tlb_pkg::*;

    apb_state_e state;
    tlb_cmd_e   cmd_dec;
    tlb_cmd_e   issue_cmd;
    tlb_cmd_e   cmd_q;

    tlb_idx_t   index_q;
    logic       probe_fail;  // Index.P
    tlb_idx_t   random_q;
    vpn2_t      vpn2_q;
    asid_t      asid_q;
    tlb_lo_t    lo0_q;
    tlb_lo_t    lo1_q;
    logic       g0_q;
    logic       g1_q;

    logic       access;
    logic       reg_write;
    logic       cmd_start;

    assign access    = psel && penable;
    assign cmd_start = access && pwrite && (paddr == 8'h14) && (state == IDLE);
    assign reg_write = access && pwrite && (paddr != 8'h14);

    always_comb begin
        case (pwdata[2:0])
            3'd1:    cmd_dec = CMD_TLBP;
            3'd2:    cmd_dec = CMD_TLBR;
            3'd3:    cmd_dec = CMD_TLBWI;
            3'd4:    cmd_dec = CMD_TLBWR;
            default: cmd_dec = CMD_NONE;
        endcase
    end

    // Command is live only in the first access cycle
    assign issue_cmd = cmd_start ? cmd_dec : CMD_NONE;

    assign pready  = !cmd_start;
    assign pslverr = 1'b0;

    assign wr_en    = (issue_cmd == CMD_TLBWI) || (issue_cmd == CMD_TLBWR);
    assign wr_idx   = (issue_cmd == CMD_TLBWR) ? random_q : index_q;
    assign wr_entry = '{vpn2: vpn2_q, asid: asid_q, g: g0_q & g1_q, lo0: lo0_q, lo1: lo1_q};

    assign probe_req  = (issue_cmd == CMD_TLBP);
    assign probe_vpn2 = vpn2_q;
    assign cur_asid   = asid_q;
    assign rd_idx     = index_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cmd_q <= CMD_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_start) begin
                        state <= CMD_WAIT;
                        cmd_q <= issue_cmd;
                    end
                end
                CMD_WAIT: begin
                    state <= IDLE;
                    cmd_q <= CMD_NONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Free-running, covers all entries with no Wired
    always_ff @(posedge clk) begin
        if (reset) begin
            random_q <= tlb_idx_t'(`TLB_NUM - 1);
        end else if (random_q == '0) begin
            random_q <= tlb_idx_t'(`TLB_NUM - 1);
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            index_q    <= '0;
            probe_fail <= 1'b0;
            vpn2_q     <= '0;
            asid_q     <= '0;
            lo0_q      <= '0;
            lo1_q      <= '0;
            g0_q       <= 1'b0;
            g1_q       <= 1'b0;
        end else if (state == CMD_WAIT) begin
            if (cmd_q == CMD_TLBP) begin
                probe_fail <= !probe_look.found;
                if (probe_look.found) begin
                    index_q <= probe_look.index;
                end
            end else if (cmd_q == CMD_TLBR) begin
                vpn2_q <= rd_entry.vpn2;
                asid_q <= rd_entry.asid;
                lo0_q  <= rd_entry.lo0;
                lo1_q  <= rd_entry.lo1;
                g0_q   <= rd_entry.g;
                g1_q   <= rd_entry.g;
            end
        end else if (reg_write) begin
            case (paddr)
                8'h00: index_q <= pwdata[`TLB_IDX_W-1:0]; // P stays read-only
                8'h08: begin
                    vpn2_q <= pwdata[31:13];
                    asid_q <= pwdata[7:0];
                end
                8'h0c: begin
                    lo0_q <= pwdata[25:1];
                    g0_q  <= pwdata[0];
                end
                8'h10: begin
                    lo1_q <= pwdata[25:1];
                    g1_q  <= pwdata[0];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            8'h00: begin
                prdata[31]              = probe_fail;
                prdata[`TLB_IDX_W-1:0]  = index_q;
            end
            8'h04:   prdata[`TLB_IDX_W-1:0] = random_q;
            8'h08:   prdata = {vpn2_q, 5'b0, asid_q};
            8'h0c:   prdata = {6'b0, lo0_q, g0_q};
            8'h10:   prdata = {6'b0, lo1_q, g1_q};
            default: prdata = '0; // Command reads back zero
        endcase
    end

endmodule

// File: verilog/mmu_translate.sv
`timescale 1ns/1ns

module mmu_translate (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_req_valid,
    input  tlb_pkg::vaddr_t      i_vaddr,
    input  logic                 d_req_valid,
    input  tlb_pkg::vaddr_t      d_vaddr,
    input  logic                 d_store,
    output logic                 d_req_ready,
    input  logic                 probe_req,
    output tlb_pkg::vpn2_t       i_vpn2,
    output tlb_pkg::vpn2_t       d_vpn2,
    input  tlb_pkg::tlb_lookup_t i_look,
    input  tlb_pkg::tlb_lookup_t d_look,
    output tlb_pkg::xlate_rsp_t  i_rsp,
    output tlb_pkg::xlate_rsp_t  d_rsp
);
    import tlb_pkg::*;

    logic        i_valid_q;
    logic        i_odd_q;
    logic [11:0] i_off_q;

    logic        d_valid_q;
    logic        d_odd_q;
    logic [11:0] d_off_q;
    logic        d_store_q;

    function automatic xlate_rsp_t form_rsp(input logic valid, input logic odd,
                                            input logic [11:0] off, input logic store,
                                            input tlb_lookup_t look);
        tlb_lo_t    lo;
        xlate_rsp_t rsp;
        lo        = odd ? look.lo1 : look.lo0;
        rsp.valid = valid;
        rsp.paddr = {lo.pfn, off};
        rsp.cattr = lo.c;
        if (!look.found) begin
            rsp.exc = EXC_REFILL;
        end else if (!lo.v) begin
            rsp.exc = EXC_INVALID;
        end else if (store && !lo.d) begin
            rsp.exc = EXC_MOD;
        end else begin
            rsp.exc = EXC_NONE;
        end
        return rsp;
    endfunction

    assign d_req_ready = !probe_req; // Data port lent to TLBP

    assign i_vpn2 = i_vaddr[31:13];
    assign d_vpn2 = d_vaddr[31:13];

    always_ff @(posedge clk) begin
        if (reset) begin
            i_valid_q <= 1'b0;
            d_valid_q <= 1'b0;
        end else begin
            i_valid_q <= i_req_valid;
            d_valid_q <= d_req_valid && d_req_ready;
        end
    end

    always_ff @(posedge clk) begin
        i_odd_q   <= i_vaddr[12];
        i_off_q   <= i_vaddr[11:0];
        d_odd_q   <= d_vaddr[12];
        d_off_q   <= d_vaddr[11:0];
        d_store_q <= d_store;
    end

    // Fetches never write
    assign i_rsp = form_rsp(i_valid_q, i_odd_q, i_off_q, 1'b0, i_look);
    assign d_rsp = form_rsp(d_valid_q, d_odd_q, d_off_q, d_store_q, d_look);

endmodule

// File: verilog/mmu_top.sv
`timescale 1ns/1ns

module mmu_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [7:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                i_req_valid,
    input  tlb_pkg::vaddr_t     i_vaddr,
    input  logic                d_req_valid,
    input  tlb_pkg::vaddr_t     d_vaddr,
    input  logic                d_store,
    output logic                d_req_ready,
    output tlb_pkg::xlate_rsp_t i_rsp,
    output tlb_pkg::xlate_rsp_t d_rsp
);
    import tlb_pkg::*;

    logic        wr_en;
    tlb_idx_t    wr_idx;
    tlb_entry_t  wr_entry;
    tlb_idx_t    rd_idx;
    tlb_entry_t  rd_entry;
    logic        probe_req;
    vpn2_t       probe_vpn2;
    asid_t       cur_asid;
    vpn2_t       i_vpn2;
    vpn2_t       d_vpn2;
    tlb_lookup_t i_look;
    tlb_lookup_t d_look;  // Also the TLBP result

    cp0_tlb_regs u_cp0_tlb_regs (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_entry   (wr_entry),
        .rd_idx     (rd_idx),
        .rd_entry   (rd_entry),
        .probe_req  (probe_req),
        .probe_vpn2 (probe_vpn2),
        .cur_asid   (cur_asid),
        .probe_look (d_look)
    );

    tlb_core u_tlb_core (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_entry   (wr_entry),
        .rd_idx     (rd_idx),
        .rd_entry   (rd_entry),
        .cur_asid   (cur_asid),
        .i_vpn2     (i_vpn2),
        .d_vpn2     (d_vpn2),
        .probe_vpn2 (probe_vpn2),
        .probe_req  (probe_req),
        .i_look     (i_look),
        .d_look     (d_look)
    );

    mmu_translate u_mmu_translate (
        .clk         (clk),
        .reset       (reset),
        .i_req_valid (i_req_valid),
        .i_vaddr     (i_vaddr),
        .d_req_valid (d_req_valid),
        .d_vaddr     (d_vaddr),
        .d_store     (d_store),
        .d_req_ready (d_req_ready),
        .probe_req   (probe_req),
        .i_vpn2      (i_vpn2),
        .d_vpn2      (d_vpn2),
        .i_look      (i_look),
        .d_look      (d_look),
        .i_rsp       (i_rsp),
        .d_rsp       (d_rsp)
    );

endmodule

// File: verif/mmu_chk.sv
`timescale 1ns/1ns

module mmu_chk (
    input logic                clk,
    input logic                reset,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input logic [7:0]          paddr,
    input logic                pready,
    input logic                probe_req,
    input logic                d_req_ready,
    input tlb_pkg::xlate_rsp_t i_rsp,
    input tlb_pkg::xlate_rsp_t d_rsp
);
    int   fail_count = 0;
    logic cmd_access;

    assign cmd_access = psel && penable && pwrite && (paddr == 8'h14);

    // Response pipeline is empty right after reset
    a_rsp_reset: assert property (@(posedge clk) reset |=> !i_rsp.valid && !d_rsp.valid)
        else begin
            fail_count++;
            $error("response valid high in the cycle after reset");
        end

    a_probe_ready: assert property (@(posedge clk) disable iff (reset)
                                    probe_req |-> !d_req_ready)
        else begin
            fail_count++;
            $error("data port ready while a probe is issued");
        end

    // Command write waits one cycle, never more
    a_cmd_wait: assert property (@(posedge clk) disable iff (reset)
                                 $rose(cmd_access) |-> !pready ##1 pready)
        else begin
            fail_count++;
            $error("Command write did not hold pready low for exactly one cycle");
        end

    a_ready_only_cmd: assert property (@(posedge clk) disable iff (reset)
                                       !pready |-> cmd_access)
        else begin
            fail_count++;
            $error("pready low outside a Command write");
        end

endmodule

bind mmu_top mmu_chk u_mmu_chk (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pready      (pready),
    .probe_req   (probe_req),
    .d_req_ready (d_req_ready),
    .i_rsp       (i_rsp),
    .d_rsp       (d_rsp)
);

// File: verif/mmu_tb.sv
`timescale 1ns/1ns
`include "tlb_defines.svh"

module mmu_tb;
    import tlb_pkg::*;

    localparam int num_tests  = 6;
    localparam int max_cycles = num_tests * 200 + 200;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        i_req_valid;
    vaddr_t      i_vaddr;
    logic        d_req_valid;
    vaddr_t      d_vaddr;
    logic        d_store;
    logic        d_req_ready;
    xlate_rsp_t  i_rsp;
    xlate_rsp_t  d_rsp;

    tlb_entry_t  model [`TLB_NUM]; // Expected TLB contents
    asid_t       cur_asid;
    int          errors;
    int          checks;
    integer      seed;
    int          cycle_count;  // Clock edges since reset
    int          access_cycle; // Cycle of the last APB access phase

    mmu_top u_mmu_top (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .i_req_valid (i_req_valid),
        .i_vaddr     (i_vaddr),
        .d_req_valid (d_req_valid),
        .d_vaddr     (d_vaddr),
        .d_store     (d_store),
        .d_req_ready (d_req_ready),
        .i_rsp       (i_rsp),
        .d_rsp       (d_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        #(max_cycles * 10);
        $display("Watchdog expired after %0d cycles, tests did not finish", max_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_rsp(input string name, input xlate_rsp_t got, input xlate_rsp_t exp);
        logic bad;
        checks++;
        bad = (got.valid !== exp.valid) || (got.exc !== exp.exc);
        if (exp.exc != EXC_REFILL) begin // Address is don't care on a miss
            bad = bad || (got.paddr !== exp.paddr) || (got.cattr !== exp.cattr);
        end
        if (bad) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_entry(input string name, input tlb_entry_t got, input tlb_entry_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] entryhi_word(input tlb_entry_t e);
        return {e.vpn2, 5'b0, e.asid};
    endfunction

    function automatic logic [31:0] entrylo_word(input tlb_lo_t lo, input logic g);
        return {6'b0, lo, g};
    endfunction

    // Random counts down once per clock from TLB_NUM-1 and wraps
    function automatic tlb_idx_t expected_random(input int cycle);
        return tlb_idx_t'(`TLB_NUM - 1 - cycle);
    endfunction

    function automatic tlb_lo_t rand_lo(input logic v, input logic d);
        tlb_lo_t lo;
        lo.pfn = pfn_t'($random(seed));
        lo.c   = cattr_t'($random(seed));
        lo.d   = d;
        lo.v   = v;
        return lo;
    endfunction

    // Expected translation from the model entries and the current ASID
    function automatic xlate_rsp_t expect_rsp(input vaddr_t va, input logic store);
        xlate_rsp_t exp;
        tlb_lo_t    lo;
        exp = '{valid: 1'b1, paddr: '0, cattr: '0, exc: EXC_REFILL};
        for (int n = 0; n < `TLB_NUM; n++) begin
            if (model[n].vpn2 == va[31:13] && (model[n].asid == cur_asid || model[n].g)) begin
                lo        = va[12] ? model[n].lo1 : model[n].lo0;
                exp.paddr = {lo.pfn, va[11:0]};
                exp.cattr = lo.c;
                if (!lo.v) begin
                    exp.exc = EXC_INVALID;
                end else if (store && !lo.d) begin
                    exp.exc = EXC_MOD;
                end else begin
                    exp.exc = EXC_NONE;
                end
            end
        end
        return exp;
    endfunction

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable      = 1'b1;
        access_cycle = cycle_count;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        check_word("pslverr", 32'(pslverr), 32'h0);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic set_asid(input asid_t asid);
        apb_write(8'h08, {19'h0, 5'b0, asid});
        cur_asid = asid;
    endtask

    task automatic write_entry(input tlb_idx_t idx, input tlb_entry_t e, input logic use_random);
        tlb_idx_t slot;
        slot = idx;
        if (!use_random) begin
            apb_write(8'h00, 32'(idx));
        end
        apb_write(8'h08, entryhi_word(e));
        apb_write(8'h0c, entrylo_word(e.lo0, e.g));
        apb_write(8'h10, entrylo_word(e.lo1, e.g));
        apb_write(8'h14, use_random ? 32'(CMD_TLBWR) : 32'(CMD_TLBWI));
        if (use_random) begin
            slot = expected_random(access_cycle); // Random at the write edge
        end
        cur_asid    = e.asid;
        model[slot] = e;
    endtask

    task automatic fetch(input vaddr_t va, input xlate_rsp_t exp, input string name);
        @(posedge clk);
        #1;
        i_req_valid = 1'b1;
        i_vaddr     = va;
        @(posedge clk);
        #1;
        i_req_valid = 1'b0;
        @(negedge clk);
        check_rsp({"i_rsp ", name}, i_rsp, exp);
        @(negedge clk);
        if (i_rsp.valid) begin
            errors++;
            $display("%s: fetch response stayed valid for a second cycle", name);
        end
    endtask

    task automatic data_access(input vaddr_t va, input logic store, input xlate_rsp_t exp,
                               input string name);
        @(posedge clk);
        #1;
        d_req_valid = 1'b1;
        d_vaddr     = va;
        d_store     = store;
        @(negedge clk);
        while (!d_req_ready) begin // Held off while a probe owns the port
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        d_req_valid = 1'b0;
        d_store     = 1'b0;
        @(negedge clk);
        check_rsp({"d_rsp ", name}, d_rsp, exp);
        @(negedge clk);
        if (d_rsp.valid) begin
            errors++;
            $display("%s: data response stayed valid for a second cycle", name);
        end
    endtask

    // One request per cycle on both ports with the data port walking the list backwards
    task automatic burst(input vaddr_t addrs[$]);
        int num;
        num = addrs.size();
        for (int k = 0; k <= num; k++) begin
            @(posedge clk);
            #1;
            i_req_valid = (k < num);
            d_req_valid = (k < num);
            if (k < num) begin
                i_vaddr = addrs[k];
                d_vaddr = addrs[num - 1 - k];
            end
            @(negedge clk);
            if (k > 0) begin
                check_rsp("burst i_rsp", i_rsp, expect_rsp(addrs[k - 1], 1'b0));
                check_rsp("burst d_rsp", d_rsp, expect_rsp(addrs[num - k], 1'b0));
            end
        end
    endtask

    task automatic reset_misses();
        xlate_rsp_t  exp;
        vaddr_t      va;
        logic [31:0] word;
        exp = '{valid: 1'b1, paddr: '0, cattr: '0, exc: EXC_REFILL};
        for (int n = 0; n < 4; n++) begin
            va = vaddr_t'($random(seed)) | 32'h8000_0000; // Keep clear of vpn2 zero
            fetch(va, exp, "reset fetch");
            data_access(va, n[0], exp, "reset data");
        end
        apb_read(8'h04, word);
        check_word("Random", word, 32'(expected_random(access_cycle)));
    endtask

    task automatic indexed_write_hits();
        int         slots[4] = '{1, 2, 5, 6};
        vaddr_t     addrs[$];
        tlb_entry_t e;
        foreach (slots[s]) begin
            e      = '0;
            e.vpn2 = vpn2_t'(19'h01000 + slots[s] * 7);
            e.asid = 8'h11;
            e.lo0  = rand_lo(1'b1, 1'b1);
            e.lo1  = rand_lo(1'b1, 1'b1);
            write_entry(tlb_idx_t'(slots[s]), e, 1'b0);
            addrs.push_back({e.vpn2, 1'b0, 12'(s * 'h155)});
            addrs.push_back({e.vpn2, 1'b1, 12'($random(seed))});
        end
        burst(addrs);
    endtask

    task automatic asid_match();
        tlb_entry_t e;
        vaddr_t     va_local;
        vaddr_t     va_global;
        e      = '0;
        e.vpn2 = 19'h02222;
        e.asid = 8'h22;
        e.g    = 1'b1;
        e.lo0  = rand_lo(1'b1, 1'b1);
        e.lo1  = rand_lo(1'b1, 1'b1);
        write_entry(3, e, 1'b0);
        va_global = {e.vpn2, 13'h0a4c};
        va_local  = {model[2].vpn2, 13'h1010};
        set_asid(8'h33);
        fetch(va_local, expect_rsp(va_local, 1'b0), "foreign asid fetch");
        data_access(va_local, 1'b0, expect_rsp(va_local, 1'b0), "foreign asid data");
        fetch(va_global, expect_rsp(va_global, 1'b0), "global fetch");
        data_access(va_global, 1'b1, expect_rsp(va_global, 1'b1), "global store");
        set_asid(8'h11);
        fetch(va_local, expect_rsp(va_local, 1'b0), "own asid fetch");
    endtask

    task automatic invalid_and_mod();
        tlb_entry_t e;
        vaddr_t     va_even;
        vaddr_t     va_odd;
        e      = '0;
        e.vpn2 = 19'h03333;
        e.asid = 8'h11;
        e.lo0  = rand_lo(1'b0, 1'b1);
        e.lo1  = rand_lo(1'b1, 1'b0);
        write_entry(7, e, 1'b0);
        va_even = {e.vpn2, 13'h0123};
        va_odd  = {e.vpn2, 13'h1fe0};
        fetch(va_even, expect_rsp(va_even, 1'b0), "invalid page fetch");
        data_access(va_even, 1'b1, expect_rsp(va_even, 1'b1), "invalid page store");
        data_access(va_odd, 1'b1, expect_rsp(va_odd, 1'b1), "clean page store");
        data_access(va_odd, 1'b0, expect_rsp(va_odd, 1'b0), "clean page load");
    endtask

    task automatic probe_and_read();
        int          reads[2] = '{3, 6};
        logic [31:0] word;
        logic [31:0] hi;
        logic [31:0] lo0w;
        logic [31:0] lo1w;
        tlb_entry_t  got;
        apb_write(8'h08, entryhi_word(model[5]));
        cur_asid = model[5].asid;
        apb_write(8'h14, 32'(CMD_TLBP));
        apb_read(8'h00, word);
        check_word("Index after probe hit", word, 32'd5);
        apb_write(8'h08, {19'h7abcd, 5'b0, cur_asid});
        apb_write(8'h14, 32'(CMD_TLBP));
        apb_read(8'h00, word);
        check_word("Index.P after probe miss", {31'b0, word[31]}, 32'd1);
        foreach (reads[r]) begin
            apb_write(8'h00, 32'(reads[r]));
            apb_write(8'h14, 32'(CMD_TLBR));
            apb_read(8'h08, hi);
            apb_read(8'h0c, lo0w);
            apb_read(8'h10, lo1w);
            got = '{vpn2: hi[31:13], asid: hi[7:0], g: lo0w[0],
                    lo0: lo0w[25:1], lo1: lo1w[25:1]};
            check_entry("TLBR entry", got, model[reads[r]]);
            check_word("EntryLo1 g after TLBR", 32'(lo1w[0]), 32'(model[reads[r]].g));
            cur_asid = model[reads[r]].asid;
        end
        set_asid(8'h11);
    endtask

    task automatic random_write();
        tlb_entry_t  e;
        xlate_rsp_t  exp;
        vaddr_t      va;
        tlb_idx_t    slot;
        logic [31:0] word;
        e      = '0;
        e.vpn2 = 19'h04444;
        e.asid = 8'h11;
        e.g    = 1'b1;
        e.lo0  = rand_lo(1'b1, 1'b1);
        e.lo1  = rand_lo(1'b1, 1'b1);
        write_entry('0, e, 1'b1);
        slot = expected_random(access_cycle);
        va   = {e.vpn2, 1'b1, 12'h3c8};
        exp  = '{valid: 1'b1, paddr: {e.lo1.pfn, 12'h3c8}, cattr: e.lo1.c, exc: EXC_NONE};
        fetch(va, exp, "TLBWR fetch");
        apb_write(8'h14, 32'(CMD_TLBP)); // EntryHi still holds the new entry
        apb_read(8'h00, word);
        check_word("Index after TLBWR probe", word, 32'(slot));
        va = {e.vpn2, 13'h0777};
        data_access(va, 1'b1, expect_rsp(va, 1'b1), "TLBWR store");
    endtask

    initial begin
        seed         = 32'h9ebc_e7ce;
        errors       = 0;
        checks       = 0;
        access_cycle = 0;
        cur_asid     = '0;
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        i_req_valid  = 1'b0;
        i_vaddr      = '0;
        d_req_valid  = 1'b0;
        d_vaddr      = '0;
        d_store      = 1'b0;
        for (int n = 0; n < `TLB_NUM; n++) begin
            model[n] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_misses();
        indexed_write_hits();
        asid_match();
        invalid_and_mod();
        probe_and_read();
        random_write();

        $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, u_mmu_top.u_mmu_chk.fail_count);
        if (errors == 0 && u_mmu_top.u_mmu_chk.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
verilog/tlb_pkg.sv
verilog/tlb_core.sv
verilog/cp0_tlb_regs.sv
verilog/mmu_translate.sv
verilog/mmu_top.sv
verif/mmu_chk.sv
verif/mmu_tb.sv

// File: run.sh
#!/bin/sh
# Build the MMU testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mmu_tb \
    -f all.f -o Vmmu_tb > build.log 2>&1 &&
./obj_dir/Vmmu_tb +verilator+error+limit+100 > sim.log 2>&1 &&
! grep -q "FAIL: see errors above" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
